/* flist.f */
+incdir+hdl
+incdir+tests
hdl/mul_op_pkg.sv
hdl/mul_regs_pkg.sv
hdl/mul_apb_regs.sv
hdl/mul_operand_prep.sv
hdl/mul_iter_core.sv
hdl/mul_unit_top.sv
tests/tb_mul_unit_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_tb
log_file=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_mul_unit_top \
  --Mdir "$build_dir" -o "$sim_bin" \
  -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "test failed" "$log_file"; then
  exit 1
fi
if ! grep -q "test passed" "$log_file"; then
  echo "No verdict found in $log_file"
  exit 1
fi
exit 0

/* tests/mul_ref_model.svh */
`ifndef MUL_REF_MODEL_SVH
`define MUL_REF_MODEL_SVH

// Low half of the product, the same for any signedness
function automatic logic [`MUL_XLEN-1:0] model_mul(input logic [`MUL_XLEN-1:0] a,
                                                   input logic [`MUL_XLEN-1:0] b);
  logic [2*`MUL_XLEN-1:0] prod;
  prod = {{`MUL_XLEN{1'b0}}, a} * {{`MUL_XLEN{1'b0}}, b};
  return prod[`MUL_XLEN-1:0];
endfunction

// Upper half with each operand taken signed or unsigned
function automatic logic [`MUL_XLEN-1:0] model_mul_high(input logic [`MUL_XLEN-1:0] a,
                                                        input logic [`MUL_XLEN-1:0] b,
                                                        input logic a_signed,
                                                        input logic b_signed);
  logic signed [2*`MUL_XLEN-1:0] prod;
  logic                          a_ext;
  logic                          b_ext;
  a_ext = a_signed & a[`MUL_XLEN-1];
  b_ext = b_signed & b[`MUL_XLEN-1];
  prod  = $signed({{`MUL_XLEN{a_ext}}, a}) * $signed({{`MUL_XLEN{b_ext}}, b});
  return prod[2*`MUL_XLEN-1:`MUL_XLEN];
endfunction

// Low word product, sign-extended to the full width
function automatic logic [`MUL_XLEN-1:0] model_mulw(input logic [`MUL_XLEN-1:0] a,
                                                    input logic [`MUL_XLEN-1:0] b);
  logic signed [63:0] prod;
  prod = $signed({{32{a[31]}}, a[31:0]}) * $signed({{32{b[31]}}, b[31:0]});
  return {{32{prod[31]}}, prod[31:0]};
endfunction

function automatic logic [`MUL_XLEN-1:0] expected_result(input logic [1:0] op,
                                                         input logic word,
                                                         input logic [`MUL_XLEN-1:0] a,
                                                         input logic [`MUL_XLEN-1:0] b);
  if (word) begin
    return model_mulw(a, b);
  end
  case (op)
    MUL_OP_MUL:    return model_mul(a, b);
    MUL_OP_MULH:   return model_mul_high(a, b, 1'b1, 1'b1);
    MUL_OP_MULHSU: return model_mul_high(a, b, 1'b1, 1'b0);
    default:       return model_mul_high(a, b, 1'b0, 1'b0);
  endcase
endfunction

`endif

/* tests/tb_mul_unit_top.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module tb_mul_unit_top;

  import mul_op_pkg::*;
  import mul_regs_pkg::*;

  `include "mul_ref_model.svh"

  localparam int N_RANDOM    = 40;
  localparam int N_TESTS     = N_RANDOM + 2;
  // About 20 APB transfers of 3 cycles each per test
  localparam int TEST_CYCLES = 100;
  localparam int MAX_POLLS   = 20;

  logic                   clk;
  logic                   rst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`MUL_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  integer seed;
  int     pass_cnt;
  int     fail_cnt;
  // Failed checks in the running test
  int     errs;

  mul_unit_top mul_unit_top_inst (
    .clk_i     (clk),
    .rst_ni    (rst),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (N_TESTS * TEST_CYCLES + 200) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("test failed");
    $finish;
  end

  // Setup and access phase with sampling in the low half of the access cycle
  task automatic apb_access(input logic write, input logic [`MUL_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("APB slave did not complete the access at %0t", $time);
      errs++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`MUL_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`MUL_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic check_value(input string what, input logic [`MUL_XLEN-1:0] got,
                             input logic [`MUL_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errs++;
    end
  endtask

  function automatic logic [`MUL_XLEN-1:0] pick_operand();
    logic [`MUL_XLEN-1:0] v;
    integer               sel;
    v   = {$random(seed), $random(seed)};
    sel = $random(seed);
    case (sel & 7)
      0:       v = '0;
      1:       v = '1;
      2:       v = {1'b1, {(`MUL_XLEN-1){1'b0}}};
      default: ;
    endcase
    return v;
  endfunction

  function automatic string op_name(input logic [MUL_OP_W-1:0] op, input logic word);
    if (word) begin
      return "MULW";
    end
    case (op)
      MUL_OP_MUL:    return "MUL";
      MUL_OP_MULH:   return "MULH";
      MUL_OP_MULHSU: return "MULHSU";
      default:       return "MULHU";
    endcase
  endfunction

  task automatic load_operands(input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
    logic err;
    apb_write(REG_OPA_LO, a[31:0], err);
    apb_write(REG_OPA_HI, a[63:32], err);
    apb_write(REG_OPB_LO, b[31:0], err);
    apb_write(REG_OPB_HI, b[63:32], err);
  endtask

  task automatic start_op(input logic [MUL_OP_W-1:0] op, input logic word, output logic err);
    logic [31:0] ctrl;
    ctrl = '0;
    ctrl[CTRL_OP_LSB +: MUL_OP_W] = op;
    ctrl[CTRL_WORD_BIT]           = word;
    apb_write(REG_CTRL, ctrl, err);
  endtask

  task automatic wait_done(output logic ok);
    logic [31:0] status;
    logic        err;
    ok = 1'b0;
    for (int n = 0; n < MAX_POLLS && !ok; n++) begin
      apb_read(REG_STATUS, status, err);
      ok = status[STAT_DONE_BIT];
    end
  endtask

  task automatic read_result(output logic [`MUL_XLEN-1:0] res);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    apb_read(REG_RES_LO, lo, err);
    apb_read(REG_RES_HI, hi, err);
    res = {hi, lo};
  endtask

  task automatic report_test(input int idx, input string name);
    if (errs == 0) begin
      pass_cnt++;
      $display("check %0d %s: ok", idx, name);
    end else begin
      fail_cnt++;
      $display("check %0d %s: FAILED", idx, name);
    end
  endtask

  task automatic run_op(input int idx, input logic [MUL_OP_W-1:0] op, input logic word,
                        input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
    logic [31:0]          status;
    logic [`MUL_XLEN-1:0] exp;
    logic [`MUL_XLEN-1:0] res;
    logic                 err;
    logic                 ok;
    string                name;
    errs = 0;
    name = op_name(op, word);
    exp  = expected_result(op, word, a, b);
    load_operands(a, b);
    start_op(op, word, err);
    if (err) begin
      $display("CTRL write for %s was rejected while idle", name);
      errs++;
    end
    apb_read(REG_STATUS, status, err);
    if (status[STAT_BUSY_BIT] !== 1'b1 || status[STAT_DONE_BIT] !== 1'b0) begin
      $display("mismatch at %0t: %s status %h right after start", $time, name, status);
      errs++;
    end
    wait_done(ok);
    if (!ok) begin
      $display("%s with a=%h b=%h never finished", name, a, b);
      errs++;
    end else begin
      read_result(res);
      check_value({name, " a=", $sformatf("%h", a), " b=", $sformatf("%h", b)}, res, exp);
      apb_read(REG_STATUS, status, err);
      if (status[STAT_BUSY_BIT] !== 1'b0 || status[STAT_DONE_BIT] !== 1'b1) begin
        $display("mismatch at %0t: %s status %h after completion", $time, name, status);
        errs++;
      end
      // Result register ignores writes
      apb_write(REG_RES_LO, 32'hdead_beef, err);
      read_result(res);
      check_value({name, " result held"}, res, exp);
    end
    report_test(idx, name);
  endtask

  task automatic busy_write_test(input int idx);
    logic [`MUL_XLEN-1:0] a;
    logic [`MUL_XLEN-1:0] b;
    logic [`MUL_XLEN-1:0] exp;
    logic [`MUL_XLEN-1:0] res;
    logic [31:0]          ctrl;
    logic                 err;
    logic                 ok;
    errs = 0;
    a    = pick_operand();
    b    = pick_operand();
    exp  = expected_result(MUL_OP_MULHU, 1'b0, a, b);
    load_operands(a, b);
    start_op(MUL_OP_MULHU, 1'b0, err);
    start_op(MUL_OP_MUL, 1'b0, err);
    if (!err) begin
      $display("CTRL write while busy gave no slave error");
      errs++;
    end
    // The rejected write must leave the running control word in place
    apb_read(REG_CTRL, ctrl, err);
    if (ctrl[CTRL_OP_LSB +: MUL_OP_W] !== MUL_OP_MULHU || ctrl[CTRL_WORD_BIT] !== 1'b0) begin
      $display("mismatch at %0t: CTRL reads %h after a rejected write", $time, ctrl);
      errs++;
    end
    wait_done(ok);
    if (!ok) begin
      $display("MULHU with a second CTRL write never finished");
      errs++;
    end else begin
      read_result(res);
      check_value("MULHU after busy CTRL write", res, exp);
    end
    report_test(idx, "busy write");
  endtask

  task automatic unmapped_test(input int idx);
    logic [31:0] data;
    logic        err;
    errs = 0;
    apb_write(8'h20, 32'h1234_5678, err);
    if (!err) begin
      $display("write to unmapped address 0x20 gave no slave error");
      errs++;
    end
    apb_read(8'h40, data, err);
    if (!err) begin
      $display("read from unmapped address 0x40 gave no slave error");
      errs++;
    end
    report_test(idx, "unmapped");
  endtask

  initial begin
    logic [`MUL_XLEN-1:0] a;
    logic [`MUL_XLEN-1:0] b;
    logic [MUL_OP_W-1:0]  op;
    logic                 word;
    seed     = 32'hf622_8872;
    pass_cnt = 0;
    fail_cnt = 0;
    errs     = 0;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Fifth slot of each five-way rotation is the word form
    for (int i = 0; i < N_RANDOM; i++) begin
      a    = pick_operand();
      b    = pick_operand();
      word = (i % 5 == 4);
      op   = word ? MUL_OP_MUL : MUL_OP_W'(i % 5);
      run_op(i, op, word, a, b);
    end
    busy_write_test(N_RANDOM);
    unmapped_test(N_RANDOM + 1);

    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hdl/mul_unit_top.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`MUL_APB_AW-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  import mul_op_pkg::*;

  logic                 req_valid;
  logic                 req_ready;
  logic [`MUL_XLEN-1:0] opa;
  logic [`MUL_XLEN-1:0] opb;
  logic [MUL_OP_W-1:0]  op;
  logic                 word;
  logic                 ext_valid;
  logic                 ext_ready;
  logic [`MUL_XLEN:0]   ext_a;
  logic [`MUL_XLEN:0]   ext_b;
  logic                 op_low;
  logic                 op_word;
  logic                 resp_valid;
  logic [`MUL_XLEN-1:0] resp_value;

  mul_apb_regs mul_apb_regs_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .req_valid_o  (req_valid),
    .req_ready_i  (req_ready),
    .opa_o        (opa),
    .opb_o        (opb),
    .op_o         (op),
    .word_o       (word),
    .resp_valid_i (resp_valid),
    .resp_value_i (resp_value)
  );

  mul_operand_prep mul_operand_prep_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .opa_i       (opa),
    .opb_i       (opb),
    .op_i        (op),
    .word_i      (word),
    .ext_valid_o (ext_valid),
    .ext_ready_i (ext_ready),
    .ext_a_o     (ext_a),
    .ext_b_o     (ext_b),
    .op_low_o    (op_low),
    .op_word_o   (op_word)
  );

  mul_iter_core mul_iter_core_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ext_valid_i  (ext_valid),
    .ext_ready_o  (ext_ready),
    .ext_a_i      (ext_a),
    .ext_b_i      (ext_b),
    .op_low_i     (op_low),
    .op_word_i    (op_word),
    .resp_valid_o (resp_valid),
    .resp_value_o (resp_value)
  );

endmodule

/* hdl/mul_iter_core.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_iter_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ext_valid_i,
  output logic                 ext_ready_o,
  input  logic [`MUL_XLEN:0]   ext_a_i,
  input  logic [`MUL_XLEN:0]   ext_b_i,
  input  logic                 op_low_i,
  input  logic                 op_word_i,
  output logic                 resp_valid_o,
  output logic [`MUL_XLEN-1:0] resp_value_o
);

  localparam logic STATE_IDLE     = 1'b0;
  localparam logic STATE_PROGRESS = 1'b1;

  localparam int LIMB_W  = `MUL_LIMB_W;
  localparam int ACC_W   = 2 * LIMB_W + 3;
  localparam int TOP_LSB = 3 * LIMB_W;

  // Columns where each operation retires
  localparam logic [2:0] COL_WORD = 3'd1;
  localparam logic [2:0] COL_LOW  = 3'd3;
  localparam logic [2:0] COL_LAST = 3'd6;

  logic                    state_q;
  logic                    state_d;
  logic [1:0]              a_idx_q;
  logic [1:0]              a_idx_d;
  logic [1:0]              b_idx_q;
  logic [1:0]              b_idx_d;
  logic [1:0]              nxt_a;
  logic [1:0]              nxt_b;
  logic                    col_end;
  logic [2:0]              col;
  logic                    accept;
  logic                    finish;
  logic                    resp_valid_d;
  logic [`MUL_XLEN:0]      a_q;
  logic [`MUL_XLEN:0]      b_q;
  logic                    op_low_q;
  logic                    op_word_q;
  logic signed [LIMB_W:0]  mac_a;
  logic signed [LIMB_W:0]  mac_b;
  logic signed [ACC_W-1:0] mac_sum;
  logic signed [ACC_W-1:0] carry;
  logic signed [ACC_W-1:0] accum_q;
  logic signed [ACC_W-1:0] accum_d;
  logic [`MUL_XLEN-1:0]    res_q;
  logic [`MUL_XLEN-1:0]    res_d;

  // Lower limbs are unsigned while the top limb carries the extension bit
  function automatic logic signed [LIMB_W:0] limb_of(input logic [`MUL_XLEN:0] opnd,
                                                    input logic [1:0]          idx);
    if (idx == 2'd3) begin
      return $signed(opnd[`MUL_XLEN:TOP_LSB]);
    end else begin
      return $signed({1'b0, opnd[idx * LIMB_W +: LIMB_W]});
    end
  endfunction

  assign ext_ready_o = (state_q == STATE_IDLE);
  assign accept      = ext_valid_i && ext_ready_o;

  assign mac_a   = limb_of(a_q, a_idx_q);
  assign mac_b   = limb_of(b_q, b_idx_q);
  assign mac_sum = accum_q + ACC_W'(mac_a) * ACC_W'(mac_b);
  assign carry   = {{LIMB_W{mac_sum[ACC_W-1]}}, mac_sum[ACC_W-1:LIMB_W]};
  assign col     = {1'b0, a_idx_q} + {1'b0, b_idx_q};

  // Limb pairs walked one column after another
  always_comb begin
    {nxt_a, nxt_b, col_end} = 5'b0;
    case ({a_idx_q, b_idx_q})
      4'b00_00: {nxt_a, nxt_b, col_end} = {2'd1, 2'd0, 1'b1};
      4'b01_00: {nxt_a, nxt_b, col_end} = {2'd0, 2'd1, 1'b0};
      4'b00_01: {nxt_a, nxt_b, col_end} = {2'd0, 2'd2, 1'b1};
      4'b00_10: {nxt_a, nxt_b, col_end} = {2'd1, 2'd1, 1'b0};
      4'b01_01: {nxt_a, nxt_b, col_end} = {2'd2, 2'd0, 1'b0};
      4'b10_00: {nxt_a, nxt_b, col_end} = {2'd3, 2'd0, 1'b1};
      4'b11_00: {nxt_a, nxt_b, col_end} = {2'd2, 2'd1, 1'b0};
      4'b10_01: {nxt_a, nxt_b, col_end} = {2'd1, 2'd2, 1'b0};
      4'b01_10: {nxt_a, nxt_b, col_end} = {2'd0, 2'd3, 1'b0};
      4'b00_11: {nxt_a, nxt_b, col_end} = {2'd1, 2'd3, 1'b1};
      4'b01_11: {nxt_a, nxt_b, col_end} = {2'd2, 2'd2, 1'b0};
      4'b10_10: {nxt_a, nxt_b, col_end} = {2'd3, 2'd1, 1'b0};
      4'b11_01: {nxt_a, nxt_b, col_end} = {2'd3, 2'd2, 1'b1};
      4'b11_10: {nxt_a, nxt_b, col_end} = {2'd2, 2'd3, 1'b0};
      4'b10_11: {nxt_a, nxt_b, col_end} = {2'd3, 2'd3, 1'b1};
      default:  {nxt_a, nxt_b, col_end} = {2'd0, 2'd0, 1'b1};
    endcase
  end

  always_comb begin
    state_d      = state_q;
    a_idx_d      = a_idx_q;
    b_idx_d      = b_idx_q;
    accum_d      = accum_q;
    res_d        = res_q;
    resp_valid_d = 1'b0;
    finish       = 1'b0;
    case (state_q)
      STATE_IDLE: begin
        if (accept) begin
          state_d = STATE_PROGRESS;
          a_idx_d = 2'd0;
          b_idx_d = 2'd0;
          accum_d = '0;
        end
      end
      default: begin
        accum_d = mac_sum;
        a_idx_d = nxt_a;
        b_idx_d = nxt_b;
        if (col_end) begin
          accum_d = carry;
          // High ops reuse the low slots for bits 64 and up
          if (col == COL_LAST) begin
            res_d[`MUL_XLEN-1:2*LIMB_W] = mac_sum[2*LIMB_W-1:0];
          end else begin
            res_d[col[1:0] * LIMB_W +: LIMB_W] = mac_sum[LIMB_W-1:0];
          end
          finish = (op_word_q && col == COL_WORD) || (op_low_q && col == COL_LOW) ||
                   (col == COL_LAST);
        end
        if (finish) begin
          if (op_word_q) begin
            res_d[`MUL_XLEN-1:2*LIMB_W] = {(`MUL_XLEN - 2 * LIMB_W){mac_sum[LIMB_W-1]}};
          end
          state_d      = STATE_IDLE;
          resp_valid_d = 1'b1;
          accum_d      = '0;
          a_idx_d      = 2'd0;
          b_idx_d      = 2'd0;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      state_q      <= STATE_IDLE;
      a_idx_q      <= 2'd0;
      b_idx_q      <= 2'd0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      a_idx_q      <= a_idx_d;
      b_idx_q      <= b_idx_d;
      resp_valid_o <= resp_valid_d;
    end
  end

  // Operands latched so prep can take the next item
  always_ff @(posedge clk_i) begin
    accum_q <= accum_d;
    res_q   <= res_d;
    if (accept) begin
      a_q       <= ext_a_i;
      b_q       <= ext_b_i;
      op_low_q  <= op_low_i;
      op_word_q <= op_word_i;
    end
  end

  assign resp_value_o = res_q;

  assert property (@(posedge clk_i) disable iff (rst_ni)
    resp_valid_o |=> !resp_valid_o);

endmodule

/* hdl/mul_operand_prep.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_operand_prep (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [`MUL_XLEN-1:0]            opa_i,
  input  logic [`MUL_XLEN-1:0]            opb_i,
  input  logic [mul_op_pkg::MUL_OP_W-1:0] op_i,
  input  logic                            word_i,
  output logic                            ext_valid_o,
  input  logic                            ext_ready_i,
  output logic [`MUL_XLEN:0]              ext_a_o,
  output logic [`MUL_XLEN:0]              ext_b_o,
  output logic                            op_low_o,
  output logic                            op_word_o
);

  import mul_op_pkg::*;

  logic take;
  logic a_sign;
  logic b_sign;
  logic ext_valid_q;

  // Stage is free when empty or drained this cycle
  assign req_ready_o = !ext_valid_q || ext_ready_i;
  assign take        = req_valid_i && req_ready_o;

  // MULHU treats a as unsigned, MULHSU and MULHU treat b as unsigned
  assign a_sign = (op_i != MUL_OP_MULHU) ? opa_i[`MUL_XLEN-1] : 1'b0;
  assign b_sign = (op_i == MUL_OP_MUL || op_i == MUL_OP_MULH) ? opb_i[`MUL_XLEN-1] : 1'b0;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      ext_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      ext_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      ext_a_o   <= {a_sign, opa_i};
      ext_b_o   <= {b_sign, opb_i};
      op_low_o  <= (op_i == MUL_OP_MUL);
      op_word_o <= word_i;
    end
  end

  assign ext_valid_o = ext_valid_q;

  assert property (@(posedge clk_i) disable iff (rst_ni)
    ext_valid_o && !ext_ready_i |=> ext_valid_o && $stable(ext_a_o) && $stable(ext_b_o)
      && $stable(op_low_o) && $stable(op_word_o));

endmodule

/* hdl/mul_apb_regs.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_apb_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [`MUL_APB_AW-1:0]          paddr_i,
  input  logic [31:0]                     pwdata_i,
  output logic [31:0]                     prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output logic                            req_valid_o,
  input  logic                            req_ready_i,
  output logic [`MUL_XLEN-1:0]            opa_o,
  output logic [`MUL_XLEN-1:0]            opb_o,
  output logic [mul_op_pkg::MUL_OP_W-1:0] op_o,
  output logic                            word_o,
  input  logic                            resp_valid_i,
  input  logic [`MUL_XLEN-1:0]            resp_value_i
);

  import mul_op_pkg::*;
  import mul_regs_pkg::*;

  localparam int HALF_W = `MUL_XLEN / 2;

  logic                 access;
  logic                 wr_en;
  logic                 addr_hit;
  logic                 ctrl_wr;
  logic                 start;
  logic                 opnd_wr;
  logic                 req_valid_q;
  logic                 busy_q;
  logic                 done_q;
  logic [MUL_OP_W-1:0]  op_q;
  logic                 word_q;
  logic [`MUL_XLEN-1:0] opa_q;
  logic [`MUL_XLEN-1:0] opb_q;
  logic [`MUL_XLEN-1:0] res_q;

  assign access  = psel_i && penable_i;
  assign wr_en   = access && pwrite_i;
  assign ctrl_wr = wr_en && (paddr_i == REG_CTRL);
  assign start   = ctrl_wr && !busy_q;
  // Operands are frozen while a request waits for acceptance
  assign opnd_wr = wr_en && !req_valid_q;

  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!addr_hit || (ctrl_wr && busy_q));

  // Read mux and address decode
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      REG_OPA_LO: prdata_o = opa_q[HALF_W-1:0];
      REG_OPA_HI: prdata_o = opa_q[`MUL_XLEN-1:HALF_W];
      REG_OPB_LO: prdata_o = opb_q[HALF_W-1:0];
      REG_OPB_HI: prdata_o = opb_q[`MUL_XLEN-1:HALF_W];
      REG_CTRL: begin
        prdata_o[CTRL_OP_LSB +: MUL_OP_W] = op_q;
        prdata_o[CTRL_WORD_BIT]           = word_q;
      end
      REG_STATUS: begin
        prdata_o[STAT_BUSY_BIT] = busy_q;
        prdata_o[STAT_DONE_BIT] = done_q;
      end
      REG_RES_LO: prdata_o = res_q[HALF_W-1:0];
      REG_RES_HI: prdata_o = res_q[`MUL_XLEN-1:HALF_W];
      default:    addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      op_q        <= '0;
      word_q      <= 1'b0;
    end else begin
      if (start) begin
        req_valid_q <= 1'b1;
        busy_q      <= 1'b1;
        done_q      <= 1'b0;
        op_q        <= pwdata_i[CTRL_OP_LSB +: MUL_OP_W];
        word_q      <= pwdata_i[CTRL_WORD_BIT];
      end else if (req_valid_q && req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (resp_valid_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (opnd_wr) begin
      case (paddr_i)
        REG_OPA_LO: opa_q[HALF_W-1:0]         <= pwdata_i;
        REG_OPA_HI: opa_q[`MUL_XLEN-1:HALF_W] <= pwdata_i;
        REG_OPB_LO: opb_q[HALF_W-1:0]         <= pwdata_i;
        REG_OPB_HI: opb_q[`MUL_XLEN-1:HALF_W] <= pwdata_i;
        default:    ;
      endcase
    end
    if (resp_valid_i) begin
      res_q <= resp_value_i;
    end
  end

  assign req_valid_o = req_valid_q;
  assign opa_o       = opa_q;
  assign opb_o       = opb_q;
  assign op_o        = op_q;
  assign word_o      = word_q;

  // One request at a time
  assert property (@(posedge clk_i) disable iff (rst_ni)
    $rose(req_valid_o) |-> !$past(busy_q));

endmodule

/* hdl/mul_regs_pkg.sv */
`include "mul_defines.svh"

package mul_regs_pkg;

  // APB register map
  localparam logic [`MUL_APB_AW-1:0] REG_OPA_LO = 8'h00;
  localparam logic [`MUL_APB_AW-1:0] REG_OPA_HI = 8'h04;
  localparam logic [`MUL_APB_AW-1:0] REG_OPB_LO = 8'h08;
  localparam logic [`MUL_APB_AW-1:0] REG_OPB_HI = 8'h0C;
  localparam logic [`MUL_APB_AW-1:0] REG_CTRL   = 8'h10;
  localparam logic [`MUL_APB_AW-1:0] REG_STATUS = 8'h14;
  localparam logic [`MUL_APB_AW-1:0] REG_RES_LO = 8'h18;
  localparam logic [`MUL_APB_AW-1:0] REG_RES_HI = 8'h1C;

  // Status register fields
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

endpackage

/* hdl/mul_op_pkg.sv */
package mul_op_pkg;

  // Width of the operation field
  localparam int MUL_OP_W = 2;

  // RISC-V M-extension multiply variants
  localparam logic [MUL_OP_W-1:0] MUL_OP_MUL    = 2'd0;
  localparam logic [MUL_OP_W-1:0] MUL_OP_MULH   = 2'd1;
  localparam logic [MUL_OP_W-1:0] MUL_OP_MULHSU = 2'd2;
  localparam logic [MUL_OP_W-1:0] MUL_OP_MULHU  = 2'd3;

  // Control word layout
  localparam int CTRL_OP_LSB   = 0;
  localparam int CTRL_WORD_BIT = 2;

endpackage

/* hdl/mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand and result width
`define MUL_XLEN 64

// APB address width
`define MUL_APB_AW 8

// Limb width of the iterative multiplier
`define MUL_LIMB_W 16

`endif
